// File: src.f
logic/ctrlPkg.sv
logic/insnDecoder.sv
logic/aluCtrlDecoder.sv
logic/cycleSequencer.sv
logic/multiCycleControl.sv
bench/controlTb.sv

// File: bench/controlTb.sv
`timescale 1ns/1ps

module controlTb import ctrlPkg::*; ();

    logic     clk;
    logic     rstn;
    opcodeT   op;
    functT    funct;
    logic     uBusy;
    logic     rxReady;
    logic     iorD, memWrite, irWrite, pcWrite, branch, toggleEqual;
    pcSrcT    pcSrc;
    aluCtrlT  aluControl;
    logic     aluSrcA;
    aluSrcBT  aluSrcB;
    logic     andiOri, regWrite;
    regDstT   regDst;
    memtoRegT memtoReg;
    logic     shiftD, shift, borL, outStrobe, txStart;
    seqStateE ctrlState;

    // per-instruction observations
    int          cycles, regWrites, memWrites, pcAluWrites;
    int          outStrobes, txStarts, outStrobeAt, txStartAt, holdCount, waitCount;
    logic        branchSeen, toggleSeen, rxSeen;
    regDstT      lastRegDst;
    memtoRegT    lastMemtoReg;
    logic [19:0] resetControls;  // datapath controls as left by reset
    opcodeT   opList [14] = '{opLw, opSw, opLui, opRtype, opBeq, opBne, opAddi,
                              opAndi, opOri, opSlti, opJ, opJal, opOut, opIn};
    functT    functList [10] = '{functAdd, functSub, functAnd, functOr, functSlt,
                                 functSll, functSrl, functJr, functJalr, 6'b100111};

    multiCycleControl multiCycleControl_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expectEqual(input string name, input int unsigned got,
                               input int unsigned exp);
        assert (got == exp) else
            reportFailure($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic stepClock;
        @(posedge clk);
        #2;  // inputs change just after the edge
    endtask

    // every registered datapath control as one vector
    function automatic logic [19:0] datapathControls();
        return {iorD, memWrite, irWrite, pcWrite, branch, toggleEqual, pcSrc, aluSrcA,
                aluSrcB, andiOri, regWrite, regDst, memtoReg, borL, outStrobe, txStart};
    endfunction

    // funct rules of the ALU decoder
    function automatic aluCtrlT functAluCtrl(input functT f);
        case (f)
            functAdd, functJr, functJalr, functSll, functSrl: return aluCtrlAdd;
            functSub: return aluCtrlSub;
            functAnd: return aluCtrlAnd;
            functOr:  return aluCtrlOr;
            functSlt: return aluCtrlSlt;
            default:  return 3'd0;
        endcase
    endfunction

    function automatic aluCtrlT immAluCtrl(input opcodeT o);
        case (o)
            opAndi:  return aluCtrlAnd;
            opOri:   return aluCtrlOr;
            opSlti:  return aluCtrlSlt;
            default: return aluCtrlAdd;
        endcase
    endfunction

    function automatic int expectedCycles(input opcodeT o, input int delay);
        case (o)
            opLw:                    return 7;
            opBeq, opBne, opJ, opJal: return 4;
            opOut, opIn:             return 6 + delay;
            default:                 return 5;
        endcase
    endfunction

    assert property (@(posedge clk) disable iff (!rstn) uBusy |-> !irWrite)
        else reportFailure("irWrite pulsed while the transmitter was busy");
    assert property (@(posedge clk) disable iff (!rstn) memWrite |-> iorD)
        else reportFailure("memWrite raised without the data address select");
    assert property (@(posedge clk) disable iff (!rstn) branch |-> (pcSrc == pcSrcBranch))
        else reportFailure("branch raised without the branch target select");

    task automatic observeCycle(input opcodeT o, input functT f);
        if (ctrlState == Fetch) begin
            expectEqual("Fetch controls", datapathControls(), resetControls);
        end
        if (regWrite) begin
            regWrites++;
            lastRegDst   = regDst;
            lastMemtoReg = memtoReg;
            if (memtoReg == memtoRegRx) begin
                assert (rxSeen) else reportFailure("receiver data written before rxReady");
            end
        end
        if (memWrite) memWrites++;
        if (pcWrite && pcSrc == pcSrcAlu && ctrlState != Fetch) pcAluWrites++;  // skip pc + 4
        if (branch) branchSeen = 1'b1;
        if (toggleEqual) toggleSeen = 1'b1;
        if (outStrobe) begin
            outStrobes++;
            outStrobeAt = cycles;
        end
        if (txStart) begin
            txStarts++;
            txStartAt = cycles;
        end
        if (multiCycleControl_i.aluOp == aluOpFunct) begin
            expectEqual("aluControl", aluControl, functAluCtrl(f));
            expectEqual("shift", shift, (f == functSll) || (f == functSrl));
            expectEqual("shiftD", shiftD, f == functSrl);
        end
        if (ctrlState == ImmExecute) expectEqual("aluControl", aluControl, immAluCtrl(o));
    endtask

    // level inputs for the out and in waits
    task automatic driveHandshake(input opcodeT o, input int delay);
        if (o == opOut && ctrlState == OutHold) begin
            if (holdCount >= delay) uBusy = 1'b0;
            holdCount++;
        end
        if (o == opIn) begin
            if (ctrlState == InWait) begin
                if (waitCount >= delay) begin
                    rxReady = 1'b1;
                    rxSeen  = 1'b1;
                end
                waitCount++;
            end else begin
                rxReady = 1'b0;
            end
        end
    endtask

    // starts in FetchWait, returns in the next FetchWait
    task automatic runInstruction(input opcodeT o, input functT f, input int delay);
        regWrites = 0;
        memWrites = 0;
        pcAluWrites = 0;
        outStrobes = 0;
        txStarts = 0;
        outStrobeAt = 0;
        txStartAt = 0;
        holdCount = 0;
        waitCount = 0;
        branchSeen = 1'b0;
        toggleSeen = 1'b0;
        rxSeen = 1'b0;
        stepClock();
        cycles = 1;
        observeCycle(o, f);
        op    = o;
        funct = f;
        if (o == opOut) uBusy = (delay > 0);
        while (1) begin
            stepClock();
            cycles++;
            if (irWrite) break;
            observeCycle(o, f);
            driveHandshake(o, delay);
            if (cycles > 50) reportFailure("timed out waiting for the next irWrite");
        end
        expectEqual("cycle count", cycles, expectedCycles(o, delay));
        case (o)
            opLw: begin
                expectEqual("regWrite cycles", regWrites, 1);
                expectEqual("memtoReg", lastMemtoReg, memtoRegMem);
                expectEqual("regDst", lastRegDst, regDstRt);
            end
            opSw: begin
                expectEqual("memWrite cycles", memWrites, 1);
                expectEqual("regWrite cycles", regWrites, 0);
            end
            opRtype: begin
                if (f == functJr || f == functJalr) begin
                    expectEqual("pcWrite alu cycles", pcAluWrites, 1);
                end
                if (f == functJalr) begin
                    expectEqual("regWrite cycles", regWrites, 1);
                    expectEqual("regDst", lastRegDst, regDstLink);
                end else if (f != functJr) begin
                    expectEqual("regWrite cycles", regWrites, 1);
                    expectEqual("regDst", lastRegDst, regDstRd);
                end
            end
            opBeq, opBne: begin
                expectEqual("regWrite cycles", regWrites, 0);
                expectEqual("memWrite cycles", memWrites, 0);
                expectEqual("branch", branchSeen, 1);
                expectEqual("toggleEqual", toggleSeen, o == opBne);
            end
            opJal: begin
                expectEqual("regWrite cycles", regWrites, 1);
                expectEqual("regDst", lastRegDst, regDstLink);
                expectEqual("memtoReg", lastMemtoReg, memtoRegPc);
            end
            opOut: begin
                expectEqual("outStrobe cycles", outStrobes, 1);
                expectEqual("txStart cycles", txStarts, 1);
                assert (outStrobeAt < txStartAt) else reportFailure("txStart came before outStrobe");
            end
            opIn: begin
                expectEqual("regWrite cycles", regWrites, 1);
                expectEqual("memtoReg", lastMemtoReg, memtoRegRx);
            end
            opAddi, opAndi, opOri, opSlti, opLui: begin
                expectEqual("regWrite cycles", regWrites, 1);
                expectEqual("regDst", lastRegDst, regDstRt);
            end
            default: ;
        endcase
    endtask

    initial begin
        int seed;
        int delay;
        opcodeT o;
        functT f;
        seed    = $urandom(32'h1535);
        rstn    = 1'b0;
        op      = '0;
        funct   = '0;
        uBusy   = 1'b0;
        rxReady = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rstn = 1'b1;
        expectEqual("ctrlState", ctrlState, Fetch);
        expectEqual("pcWrite", pcWrite, 1);
        expectEqual("aluSrcB", aluSrcB, aluSrcBFour);
        expectEqual("andiOri", andiOri, 1);
        expectEqual("strobes", {irWrite, memWrite, regWrite, txStart, outStrobe, branch}, 0);
        resetControls = datapathControls();
        cycles = 0;
        while (!irWrite) begin
            stepClock();
            cycles++;
            if (cycles > 50) reportFailure("timed out waiting for the first irWrite");
        end
        expectEqual("first irWrite delay", cycles, 1);
        runInstruction(opLw, '0, 0);
        runInstruction(opSw, '0, 0);
        runInstruction(opLui, '0, 0);
        for (int i = 0; i < 10; i++) begin
            runInstruction(opRtype, functList[i], 0);  // every funct incl. unknown
        end
        runInstruction(opBeq, '0, 0);
        runInstruction(opBne, '0, 0);
        runInstruction(opAddi, '0, 0);
        runInstruction(opAndi, '0, 0);
        runInstruction(opOri, '0, 0);
        runInstruction(opSlti, '0, 0);
        runInstruction(opJ, '0, 0);
        runInstruction(opJal, '0, 0);
        runInstruction(opOut, '0, 0);
        runInstruction(opOut, '0, 3);
        runInstruction(opIn, '0, 0);
        runInstruction(opIn, '0, 4);
        for (int i = 0; i < 60; i++) begin
            o     = opList[$urandom % 14];
            f     = (o == opRtype) ? functList[$urandom % 10] : functT'($urandom);
            delay = $urandom % 5;
            runInstruction(o, f, delay);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: logic/multiCycleControl.sv
`timescale 1ns/1ps

module multiCycleControl import ctrlPkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  opcodeT   op,
    input  functT    funct,
    input  logic     uBusy,
    input  logic     rxReady,
    output logic     iorD,
    output logic     memWrite,
    output logic     irWrite,
    output logic     pcWrite,
    output logic     branch,
    output logic     toggleEqual,
    output pcSrcT    pcSrc,
    output aluCtrlT  aluControl,
    output logic     aluSrcA,
    output aluSrcBT  aluSrcB,
    output logic     andiOri,
    output logic     regWrite,
    output regDstT   regDst,
    output memtoRegT memtoReg,
    output logic     shiftD,
    output logic     shift,
    output logic     borL,
    output logic     outStrobe,
    output logic     txStart,
    output seqStateE ctrlState
);

    insnClassE insnClass;
    aluOpT     immAluOp;
    aluOpT     aluOp;

    insnDecoder insnDecoder_i (
        .op        (op),
        .funct     (funct),
        .insnClass (insnClass),
        .immAluOp  (immAluOp)
    );

    cycleSequencer cycleSequencer_i (
        .clk         (clk),
        .rstn        (rstn),
        .insnClass   (insnClass),
        .immAluOp    (immAluOp),
        .uBusy       (uBusy),
        .rxReady     (rxReady),
        .aluOp       (aluOp),
        .iorD        (iorD),
        .memWrite    (memWrite),
        .irWrite     (irWrite),
        .pcWrite     (pcWrite),
        .branch      (branch),
        .toggleEqual (toggleEqual),
        .pcSrc       (pcSrc),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .andiOri     (andiOri),
        .regWrite    (regWrite),
        .regDst      (regDst),
        .memtoReg    (memtoReg),
        .borL        (borL),
        .outStrobe   (outStrobe),
        .txStart     (txStart),
        .ctrlState   (ctrlState)
    );

    // funct also feeds the ALU decoder directly
    aluCtrlDecoder aluCtrlDecoder_i (
        .aluOp      (aluOp),
        .funct      (funct),
        .aluControl (aluControl),
        .shiftD     (shiftD),
        .shift      (shift)
    );

endmodule

// File: logic/cycleSequencer.sv
`timescale 1ns/1ps

module cycleSequencer import ctrlPkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  insnClassE insnClass,
    input  aluOpT     immAluOp,
    input  logic      uBusy,
    input  logic      rxReady,
    output aluOpT     aluOp,
    output logic      iorD,
    output logic      memWrite,
    output logic      irWrite,
    output logic      pcWrite,
    output logic      branch,
    output logic      toggleEqual,
    output pcSrcT     pcSrc,
    output logic      aluSrcA,
    output aluSrcBT   aluSrcB,
    output logic      andiOri,
    output logic      regWrite,
    output regDstT    regDst,
    output memtoRegT  memtoReg,
    output logic      borL,
    output logic      outStrobe,
    output logic      txStart,
    output seqStateE  ctrlState
);

    // idle datapath setting, used on reset and on every return to Fetch
    task restoreDefaults;
        iorD        <= 1'b0;
        memWrite    <= 1'b0;
        irWrite     <= 1'b0;
        pcWrite     <= 1'b1;  // pc + 4 in Fetch
        branch      <= 1'b0;
        toggleEqual <= 1'b0;
        pcSrc       <= pcSrcAlu;
        aluSrcA     <= 1'b0;
        aluSrcB     <= aluSrcBFour;
        andiOri     <= 1'b1;
        regWrite    <= 1'b0;
        regDst      <= regDstRt;
        memtoReg    <= memtoRegAlu;
        borL        <= 1'b0;
        outStrobe   <= 1'b0;
        txStart     <= 1'b0;
        aluOp       <= aluOpAdd;
    endtask

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ctrlState <= Fetch;
            restoreDefaults();
        end else begin
            case (ctrlState)
                Fetch: begin
                    ctrlState <= FetchWait;
                    pcWrite   <= 1'b0;
                    irWrite   <= 1'b1;  // IR loads in FetchWait
                end
                FetchWait: begin
                    ctrlState <= Decode;
                    irWrite   <= 1'b0;
                    aluSrcB   <= aluSrcBShImm;  // precompute branch target
                end
                Decode: begin
                    case (insnClass)
                        classLoad, classStore: begin
                            ctrlState <= MemAdr;
                            aluSrcA   <= 1'b1;
                            aluSrcB   <= aluSrcBImm;
                            aluOp     <= aluOpAdd;
                        end
                        classLui: begin
                            ctrlState <= LoadUi;
                            aluSrcA   <= 1'b1;
                            aluSrcB   <= aluSrcBShImm;
                            borL      <= 1'b1;
                            aluOp     <= aluOpAdd;
                        end
                        classRtype, classJr: begin
                            ctrlState <= Execute;
                            aluSrcA   <= 1'b1;
                            aluSrcB   <= aluSrcBReg;
                            aluOp     <= aluOpFunct;
                            if (insnClass == classJr) begin
                                pcWrite <= 1'b1;  // pc <= rs
                                pcSrc   <= pcSrcAlu;
                            end
                        end
                        classJalr: begin
                            ctrlState <= JumpLinkReg;
                            aluSrcA   <= 1'b1;
                            aluSrcB   <= aluSrcBReg;
                            aluOp     <= aluOpFunct;
                            pcWrite   <= 1'b1;
                            pcSrc     <= pcSrcAlu;
                            regWrite  <= 1'b1;
                            regDst    <= regDstLink;
                            memtoReg  <= memtoRegPc;
                        end
                        classBeq, classBne: begin
                            ctrlState   <= (insnClass == classBne) ? BranchNe : Branch;
                            aluSrcA     <= 1'b1;
                            aluSrcB     <= aluSrcBReg;
                            aluOp       <= aluOpSub;
                            pcSrc       <= pcSrcBranch;
                            branch      <= 1'b1;
                            toggleEqual <= (insnClass == classBne);  // invert zero flag
                        end
                        classAddi, classAndi, classOri, classSlti: begin
                            ctrlState <= ImmExecute;
                            aluSrcA   <= 1'b1;
                            aluSrcB   <= aluSrcBImm;
                            aluOp     <= immAluOp;
                        end
                        classJump: begin
                            ctrlState <= Jump;
                            pcSrc     <= pcSrcJump;
                            pcWrite   <= 1'b1;
                        end
                        classJal: begin
                            ctrlState <= JumpLink;
                            pcSrc     <= pcSrcJump;
                            pcWrite   <= 1'b1;
                            regWrite  <= 1'b1;
                            regDst    <= regDstLink;
                            memtoReg  <= memtoRegPc;
                        end
                        classOut: begin
                            ctrlState <= OutPre;
                            outStrobe <= 1'b1;
                        end
                        classIn: begin
                            ctrlState <= InWait;
                        end
                        default: begin
                            ctrlState <= Decode;  // illegal opcode, stuck
                        end
                    endcase
                end
                MemAdr: begin
                    iorD <= 1'b1;  // data side of memory
                    if (insnClass == classStore) begin
                        ctrlState <= MemWrite;
                        memWrite  <= 1'b1;
                    end else begin
                        ctrlState <= MemRead;
                    end
                end
                MemRead: begin
                    ctrlState <= MemReadWait;  // memory read latency
                end
                MemReadWait: begin
                    ctrlState <= MemWriteback;
                    regDst    <= regDstRt;
                    memtoReg  <= memtoRegMem;
                    regWrite  <= 1'b1;
                end
                Execute: begin
                    ctrlState <= AluWriteback;
                    pcWrite   <= 1'b0;
                    regDst    <= regDstRd;
                    memtoReg  <= memtoRegAlu;
                    regWrite  <= 1'b1;
                end
                JumpLinkReg: begin
                    // link already written, just close the pc update
                    ctrlState <= AluWriteback;
                    pcWrite   <= 1'b0;
                    regWrite  <= 1'b0;
                end
                LoadUi: begin
                    ctrlState <= LuiWriteback;
                    borL      <= 1'b0;
                    regDst    <= regDstRt;
                    memtoReg  <= memtoRegAlu;
                    regWrite  <= 1'b1;
                end
                ImmExecute: begin
                    ctrlState <= ImmWriteback;
                    andiOri   <= 1'b0;
                    regDst    <= regDstRt;
                    memtoReg  <= memtoRegAlu;
                    regWrite  <= 1'b1;
                end
                OutPre: begin
                    ctrlState <= OutWait;
                    outStrobe <= 1'b0;
                    txStart   <= 1'b1;
                end
                OutWait: begin
                    ctrlState <= OutHold;
                    txStart   <= 1'b0;
                end
                OutHold: begin
                    if (!uBusy) begin  // transmitter done
                        ctrlState <= Fetch;
                        restoreDefaults();
                    end
                end
                InWait: begin
                    if (rxReady) begin
                        ctrlState <= InPre;
                    end
                end
                InPre: begin
                    ctrlState <= InDone;
                    regDst    <= regDstRt;
                    memtoReg  <= memtoRegRx;
                    regWrite  <= 1'b1;
                end
                MemWriteback, MemWrite, AluWriteback, LuiWriteback, ImmWriteback,
                Branch, BranchNe, Jump, JumpLink, InDone: begin
                    ctrlState <= Fetch;
                    restoreDefaults();
                end
                default: begin
                    ctrlState <= Fetch;
                    restoreDefaults();
                end
            endcase
        end
    end

endmodule

// File: logic/aluCtrlDecoder.sv
`timescale 1ns/1ps

module aluCtrlDecoder import ctrlPkg::*; (
    input  aluOpT   aluOp,
    input  functT   funct,
    output aluCtrlT aluControl,
    output logic    shiftD,
    output logic    shift
);

    always_comb begin
        aluControl = aluCtrlAdd;
        shift      = 1'b0;
        shiftD     = 1'b0;
        case (aluOp)
            aluOpAdd: aluControl = aluCtrlAdd;
            aluOpSub: aluControl = aluCtrlSub;
            aluOpAnd: aluControl = aluCtrlAnd;
            aluOpOr:  aluControl = aluCtrlOr;
            aluOpSlt: aluControl = aluCtrlSlt;
            aluOpFunct: begin
                case (funct)
                    functAdd, functJr, functJalr: begin
                        aluControl = aluCtrlAdd;
                    end
                    functSll: begin
                        aluControl = aluCtrlAdd;  // shifter bypasses ALU result
                        shift      = 1'b1;
                    end
                    functSrl: begin
                        aluControl = aluCtrlAdd;
                        shift      = 1'b1;
                        shiftD     = 1'b1;  // right
                    end
                    functSub: begin
                        aluControl = aluCtrlSub;
                    end
                    functAnd: begin
                        aluControl = aluCtrlAnd;
                    end
                    functOr: begin
                        aluControl = aluCtrlOr;
                    end
                    functSlt: begin
                        aluControl = aluCtrlSlt;
                    end
                    default: begin
                        aluControl = '0;  // unknown funct
                    end
                endcase
            end
            default: begin
                aluControl = '0;
            end
        endcase
    end

endmodule

// File: logic/insnDecoder.sv
`timescale 1ns/1ps

module insnDecoder import ctrlPkg::*; (
    input  opcodeT    op,
    input  functT     funct,
    output insnClassE insnClass,
    output aluOpT     immAluOp
);

    always_comb begin
        insnClass = classIllegal;
        immAluOp  = aluOpAdd;  // don't care outside immediates
        case (op)
            opLw: begin
                insnClass = classLoad;
            end
            opSw: begin
                insnClass = classStore;
            end
            opLui: begin
                insnClass = classLui;
            end
            opRtype: begin
                // jr and jalr share opcode zero
                if (funct == functJr) begin
                    insnClass = classJr;
                end else if (funct == functJalr) begin
                    insnClass = classJalr;
                end else begin
                    insnClass = classRtype;
                end
            end
            opBeq: begin
                insnClass = classBeq;
            end
            opBne: begin
                insnClass = classBne;
            end
            opAddi: begin
                insnClass = classAddi;
                immAluOp  = aluOpAdd;
            end
            opAndi: begin
                insnClass = classAndi;
                immAluOp  = aluOpAnd;
            end
            opOri: begin
                insnClass = classOri;
                immAluOp  = aluOpOr;
            end
            opSlti: begin
                insnClass = classSlti;
                immAluOp  = aluOpSlt;
            end
            opJ: begin
                insnClass = classJump;
            end
            opJal: begin
                insnClass = classJal;
            end
            opOut: begin
                insnClass = classOut;
            end
            opIn: begin
                insnClass = classIn;
            end
            default: begin
                insnClass = classIllegal;  // sequencer parks in Decode
            end
        endcase
    end

endmodule

// File: logic/ctrlPkg.sv
package ctrlPkg;

    // instruction fields
    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    // datapath control vectors
    typedef logic [2:0] aluOpT;
    typedef logic [2:0] aluCtrlT;
    typedef logic [1:0] pcSrcT;
    typedef logic [1:0] regDstT;
    typedef logic [1:0] memtoRegT;
    typedef logic [1:0] aluSrcBT;

    // op from sequencer to the ALU decoder
    localparam aluOpT aluOpAdd   = 3'd0;
    localparam aluOpT aluOpSub   = 3'd1;
    localparam aluOpT aluOpAnd   = 3'd2;
    localparam aluOpT aluOpOr    = 3'd3;
    localparam aluOpT aluOpSlt   = 3'd4;
    localparam aluOpT aluOpFunct = 3'd7;  // look at funct field

    localparam aluCtrlT aluCtrlAnd = 3'd0;
    localparam aluCtrlT aluCtrlOr  = 3'd1;
    localparam aluCtrlT aluCtrlAdd = 3'd2;
    localparam aluCtrlT aluCtrlSub = 3'd6;
    localparam aluCtrlT aluCtrlSlt = 3'd7;

    localparam pcSrcT pcSrcAlu    = 2'd0;
    localparam pcSrcT pcSrcBranch = 2'd1;
    localparam pcSrcT pcSrcJump   = 2'd2;

    localparam regDstT regDstRt   = 2'd0;
    localparam regDstT regDstRd   = 2'd1;
    localparam regDstT regDstLink = 2'd2;  // $ra

    localparam memtoRegT memtoRegAlu = 2'd0;
    localparam memtoRegT memtoRegMem = 2'd1;
    localparam memtoRegT memtoRegPc  = 2'd2;
    localparam memtoRegT memtoRegRx  = 2'd3;  // serial receiver data

    localparam aluSrcBT aluSrcBReg   = 2'd0;
    localparam aluSrcBT aluSrcBFour  = 2'd1;
    localparam aluSrcBT aluSrcBImm   = 2'd2;
    localparam aluSrcBT aluSrcBShImm = 2'd3;  // imm << 2

    // opcodes
    localparam opcodeT opRtype = 6'b000000;
    localparam opcodeT opJ     = 6'b000010;
    localparam opcodeT opJal   = 6'b000011;
    localparam opcodeT opBeq   = 6'b000100;
    localparam opcodeT opBne   = 6'b000101;
    localparam opcodeT opAddi  = 6'b001000;
    localparam opcodeT opSlti  = 6'b001010;
    localparam opcodeT opAndi  = 6'b001100;
    localparam opcodeT opOri   = 6'b001101;
    localparam opcodeT opLui   = 6'b001111;
    localparam opcodeT opIn    = 6'b011010;
    localparam opcodeT opOut   = 6'b011011;
    localparam opcodeT opLw    = 6'b100011;
    localparam opcodeT opSw    = 6'b101011;

    // function codes under opRtype
    localparam functT functSll  = 6'b000000;
    localparam functT functSrl  = 6'b000010;
    localparam functT functJr   = 6'b001000;
    localparam functT functJalr = 6'b001001;
    localparam functT functAdd  = 6'b100000;
    localparam functT functSub  = 6'b100010;
    localparam functT functAnd  = 6'b100100;
    localparam functT functOr   = 6'b100101;
    localparam functT functSlt  = 6'b101010;

    typedef enum logic [4:0] {
        classLoad, classStore, classLui, classRtype, classJr, classJalr,
        classBeq, classBne, classAddi, classAndi, classOri, classSlti,
        classJump, classJal, classOut, classIn, classIllegal
    } insnClassE;

    typedef enum logic [5:0] {
        Fetch, FetchWait, Decode, MemAdr, MemRead, MemReadWait, MemWriteback,
        MemWrite, Execute, AluWriteback, LoadUi, LuiWriteback, ImmExecute,
        ImmWriteback, Branch, BranchNe, Jump, JumpLink, JumpLinkReg,
        OutPre, OutWait, OutHold, InWait, InPre, InDone
    } seqStateE;

endpackage
